// ==== robCore_defines.svh ====
`ifndef ROBCORE_DEFINES_SVH
`define ROBCORE_DEFINES_SVH

// instructions per dispatch and per retire
`define NUM_SUPER 2

// must stay a power of two
`define NUM_ROB 16

`define NUM_AREG 32
`define NUM_PREG 48

// index widths
`define ROB_IDX_W 4
`define AREG_W 5
`define PREG_W 6

`endif

// ==== robPkg.sv ====
`default_nettype none

`include "robCore_defines.svh"

package robPkg;

  typedef struct packed {
    logic [`AREG_W-1:0] dest;
    logic               halt;
    logic               illegal;
  } instrIn_t;

  typedef instrIn_t [`NUM_SUPER-1:0] dispatchReq_t;

  typedef struct packed {
    logic [`AREG_W-1:0] dest;
    logic [`PREG_W-1:0] tag;
    logic [`PREG_W-1:0] oldTag;
    logic               halt;
    logic               illegal;
  } renamed_t;

  typedef renamed_t [`NUM_SUPER-1:0] renamedPair_t;

  typedef struct packed {
    logic     valid;
    logic     complete;
    renamed_t instr;
  } robEntry_t;

  typedef struct packed {
    logic                  valid;
    logic [`ROB_IDX_W-1:0] idx;
  } completePort_t;

  typedef completePort_t [`NUM_SUPER-1:0] completeReq_t;

endpackage

`default_nettype wire

// ==== commitPkg.sv ====
`default_nettype none

`include "robCore_defines.svh"

package commitPkg;

  typedef struct packed {
    logic               valid;
    logic [`AREG_W-1:0] dest;
    logic [`PREG_W-1:0] tag;
    logic [`PREG_W-1:0] oldTag;
    logic               halt;
    logic               illegal;
  } retireSlot_t;

  typedef retireSlot_t [`NUM_SUPER-1:0] retirePair_t;

  // tag handed back to the free list
  typedef struct packed {
    logic               valid;
    logic [`PREG_W-1:0] tag;
  } freedTag_t;

  typedef freedTag_t [`NUM_SUPER-1:0] freedTags_t;

endpackage

`default_nettype wire

// ==== renameStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "robCore_defines.svh"

module renameStage (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatchValid,
  input  robPkg::dispatchReq_t  dispatchReq,
  input  commitPkg::freedTags_t freedTags,
  output logic                  renamedValid,
  output robPkg::renamedPair_t  renamed,
  output logic [`PREG_W:0]      freeCount
);
  import robPkg::*;
  import commitPkg::*;

  localparam int FL_DEPTH = `NUM_PREG - `NUM_AREG;
  localparam int FL_IDX_W = $clog2(FL_DEPTH);

  logic [`PREG_W-1:0] freeList [FL_DEPTH];
  logic [FL_IDX_W-1:0] flHead;
  logic [FL_IDX_W-1:0] flTail;
  logic [FL_IDX_W-1:0] pushIdx1;
  logic [1:0] pushCount;
  logic [`PREG_W-1:0] specMap [`NUM_AREG];
  renamedPair_t renamedNext;

  // slot 1 lands behind slot 0 only when slot 0 pushes too
  assign pushIdx1 = flTail + FL_IDX_W'(freedTags[0].valid);
  assign pushCount = 2'(freedTags[0].valid) + 2'(freedTags[1].valid);

  always_comb begin
    for (int i = 0; i < `NUM_SUPER; i++) begin
      renamedNext[i].dest = dispatchReq[i].dest;
      renamedNext[i].tag = freeList[flHead + FL_IDX_W'(i)];
      renamedNext[i].oldTag = specMap[dispatchReq[i].dest];
      renamedNext[i].halt = dispatchReq[i].halt;
      renamedNext[i].illegal = dispatchReq[i].illegal;
    end
    // same destination inside a pair
    if (dispatchReq[1].dest == dispatchReq[0].dest) begin
      renamedNext[1].oldTag = renamedNext[0].tag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      flHead <= '0;
      flTail <= '0;
      freeCount <= (`PREG_W+1)'(FL_DEPTH);
      for (int i = 0; i < FL_DEPTH; i++) begin
        freeList[i] <= `PREG_W'(`NUM_AREG + i);
      end
      // identity mapping
      for (int i = 0; i < `NUM_AREG; i++) begin
        specMap[i] <= `PREG_W'(i);
      end
    end else begin
      if (freedTags[0].valid) begin
        freeList[flTail] <= freedTags[0].tag;
      end
      if (freedTags[1].valid) begin
        freeList[pushIdx1] <= freedTags[1].tag;
      end
      flTail <= flTail + FL_IDX_W'(pushCount);
      if (dispatchValid) begin
        flHead <= flHead + FL_IDX_W'(`NUM_SUPER);
        // slot 1 wins on a shared destination
        specMap[dispatchReq[0].dest] <= renamedNext[0].tag;
        specMap[dispatchReq[1].dest] <= renamedNext[1].tag;
      end
      freeCount <= freeCount + (`PREG_W+1)'(pushCount)
                   - (dispatchValid ? (`PREG_W+1)'(`NUM_SUPER) : '0);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      renamedValid <= 1'b0;
    end else begin
      renamedValid <= dispatchValid;
    end
  end

  always_ff @(posedge clock) begin
    if (dispatchValid) begin
      renamed <= renamedNext;
    end
  end

endmodule

`default_nettype wire

// ==== reorderBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "robCore_defines.svh"

module reorderBuffer (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   renamedValid,
  input  robPkg::renamedPair_t   renamed,
  input  robPkg::completeReq_t   completeReq,
  input  logic                   halted,
  output commitPkg::retirePair_t retireNow,
  output logic [`ROB_IDX_W:0]    robSpace
);
  import robPkg::*;
  import commitPkg::*;

  robEntry_t entries [`NUM_ROB];
  robEntry_t entriesNext [`NUM_ROB];
  logic [`ROB_IDX_W-1:0] head;
  logic [`ROB_IDX_W-1:0] tail;
  logic [`ROB_IDX_W-1:0] headPlusOne;
  logic [`ROB_IDX_W-1:0] tailPlusOne;
  logic [`ROB_IDX_W:0] used;
  logic [`NUM_SUPER-1:0] retireEn;
  logic [1:0] retireCount;

  function automatic retireSlot_t toSlot(input logic en, input renamed_t r);
    retireSlot_t s;
    s.valid = en;
    s.dest = r.dest;
    s.tag = r.tag;
    s.oldTag = r.oldTag;
    s.halt = r.halt;
    s.illegal = r.illegal;
    return s;
  endfunction

  assign headPlusOne = head + 1'b1;
  assign tailPlusOne = tail + 1'b1;

  // in-order retire, slot 1 only behind slot 0
  always_comb begin
    retireEn[0] = entries[head].valid & entries[head].complete & ~halted;
    retireEn[1] = retireEn[0] & entries[headPlusOne].valid & entries[headPlusOne].complete;
  end

  assign retireCount = 2'(retireEn[0]) + 2'(retireEn[1]);

  always_comb begin
    retireNow[0] = toSlot(retireEn[0], entries[head].instr);
    retireNow[1] = toSlot(retireEn[1], entries[headPlusOne].instr);
  end

  // a pair sitting in the rename register already owns two slots
  assign robSpace = (`ROB_IDX_W+1)'(`NUM_ROB) - used
                    - (renamedValid ? (`ROB_IDX_W+1)'(`NUM_SUPER) : '0);

  always_comb begin
    entriesNext = entries;
    if (renamedValid) begin
      entriesNext[tail].valid = 1'b1;
      entriesNext[tail].complete = renamed[0].halt | renamed[0].illegal;
      entriesNext[tail].instr = renamed[0];
      entriesNext[tailPlusOne].valid = 1'b1;
      entriesNext[tailPlusOne].complete = renamed[1].halt | renamed[1].illegal;
      entriesNext[tailPlusOne].instr = renamed[1];
    end
    for (int i = 0; i < `NUM_SUPER; i++) begin
      if (completeReq[i].valid) begin
        entriesNext[completeReq[i].idx].complete = 1'b1;
      end
    end
    if (retireEn[0]) begin
      entriesNext[head].valid = 1'b0;
    end
    if (retireEn[1]) begin
      entriesNext[headPlusOne].valid = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_ROB; i++) begin
        entries[i].valid <= 1'b0;
        entries[i].complete <= 1'b0;
      end
    end else begin
      entries <= entriesNext;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      used <= '0;
    end else begin
      head <= head + `ROB_IDX_W'(retireCount);
      if (renamedValid) begin
        tail <= tail + `ROB_IDX_W'(`NUM_SUPER);
      end
      used <= used - (`ROB_IDX_W+1)'(retireCount)
              + (renamedValid ? (`ROB_IDX_W+1)'(`NUM_SUPER) : '0);
    end
  end

endmodule

`default_nettype wire

// ==== commitStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "robCore_defines.svh"

module commitStage (
  input  logic                   clock,
  input  logic                   reset,
  input  commitPkg::retirePair_t retireNow,
  output commitPkg::retirePair_t retired,
  output commitPkg::freedTags_t  freedTags,
  output logic                   halted,
  output logic                   illegalSeen
);
  import commitPkg::*;

  logic [`PREG_W-1:0] archMap [`NUM_AREG];
  retirePair_t report;
  freedTags_t freedNext;
  logic stopSeen;
  logic haltNow;
  logic illegalNow;

  // drop anything younger than a halting slot
  always_comb begin
    report = retireNow;
    stopSeen = 1'b0;
    haltNow = 1'b0;
    illegalNow = 1'b0;
    for (int i = 0; i < `NUM_SUPER; i++) begin
      report[i].valid = retireNow[i].valid & ~stopSeen;
      haltNow = haltNow | (report[i].valid & report[i].halt);
      illegalNow = illegalNow | (report[i].valid & report[i].illegal);
      stopSeen = stopSeen | (report[i].valid & (report[i].halt | report[i].illegal));
    end
  end

  // freed tag is the architectural mapping being replaced
  always_comb begin
    freedNext[0].valid = report[0].valid;
    freedNext[0].tag = archMap[report[0].dest];
    freedNext[1].valid = report[1].valid;
    freedNext[1].tag = (report[0].valid && report[0].dest == report[1].dest) ?
                       report[0].tag : archMap[report[1].dest];
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      retired <= '0;
      freedTags <= '0;
      halted <= 1'b0;
      illegalSeen <= 1'b0;
      for (int i = 0; i < `NUM_AREG; i++) begin
        archMap[i] <= `PREG_W'(i);
      end
    end else begin
      retired <= report;
      freedTags <= freedNext;
      halted <= halted | haltNow;
      illegalSeen <= illegalSeen | illegalNow;
      for (int i = 0; i < `NUM_SUPER; i++) begin
        if (report[i].valid) begin
          archMap[report[i].dest] <= report[i].tag;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== robCore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "robCore_defines.svh"

module robCore (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dispatchValid,
  input  robPkg::dispatchReq_t   dispatchReq,
  input  robPkg::completeReq_t   completeReq,
  output logic                   dispatchReady,
  output commitPkg::retirePair_t retired,
  output logic                   halted,
  output logic                   illegalSeen
);
  import robPkg::*;
  import commitPkg::*;

  logic dispatchAccept;
  logic dispatchBlock;
  logic stopped;
  logic renamedValid;
  renamedPair_t renamed;
  logic [`PREG_W:0] freeCount;
  logic [`ROB_IDX_W:0] robSpace;
  retirePair_t retireNow;
  freedTags_t freedTags;

  assign stopped = halted | illegalSeen;

  // room for two pairs, two free tags, not stopped, no strobe last cycle
  assign dispatchReady = (robSpace >= (`ROB_IDX_W+1)'(2 * `NUM_SUPER))
                         & (freeCount >= (`PREG_W+1)'(`NUM_SUPER))
                         & ~stopped & ~dispatchBlock;
  assign dispatchAccept = dispatchValid & dispatchReady;

  // also keeps ready low in the first cycle out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      dispatchBlock <= 1'b1;
    end else begin
      dispatchBlock <= dispatchAccept;
    end
  end

  renameStage renameStage_inst (
    .clock(clock),
    .reset(reset),
    .dispatchValid(dispatchAccept),
    .dispatchReq(dispatchReq),
    .freedTags(freedTags),
    .renamedValid(renamedValid),
    .renamed(renamed),
    .freeCount(freeCount)
  );

  reorderBuffer reorderBuffer_inst (
    .clock(clock),
    .reset(reset),
    .renamedValid(renamedValid),
    .renamed(renamed),
    .completeReq(completeReq),
    .halted(stopped),
    .retireNow(retireNow),
    .robSpace(robSpace)
  );

  commitStage commitStage_inst (
    .clock(clock),
    .reset(reset),
    .retireNow(retireNow),
    .retired(retired),
    .freedTags(freedTags),
    .halted(halted),
    .illegalSeen(illegalSeen)
  );

endmodule

`default_nettype wire

// ==== robCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "robCore_defines.svh"

module robCoreTb;
  import robPkg::*;
  import commitPkg::*;

  localparam int NUM_ROWS = 22;
  localparam int FL_DEPTH = `NUM_PREG - `NUM_AREG;
  localparam logic [2:0] MODE_HOLD = 3'd0;
  localparam logic [2:0] MODE_INORDER = 3'd1;
  localparam logic [2:0] MODE_REVERSE = 3'd2;
  localparam logic [2:0] MODE_RANDOM = 3'd3;
  localparam logic [2:0] MODE_TIMING = 3'd4;
  localparam logic [2:0] MODE_FULL = 3'd5;
  localparam logic [2:0] MODE_STOP = 3'd6;

  typedef struct packed {
    dispatchReq_t req;
    logic [2:0]   mode;
  } stimRow_t;

  logic clock;
  logic reset;
  logic dispatchValid;
  dispatchReq_t dispatchReq;
  completeReq_t completeReq;
  logic dispatchReady;
  retirePair_t retired;
  logic halted;
  logic illegalSeen;

  stimRow_t stim [NUM_ROWS];

  // reference model state
  logic [`PREG_W-1:0] freeTags [$];
  logic [`PREG_W-1:0] specMap [`NUM_AREG];
  logic [`PREG_W-1:0] archMap [`NUM_AREG];
  retireSlot_t expectedQ [$];
  logic [`ROB_IDX_W-1:0] pendingIdx [$];
  int pairCount;
  logic expHalted;
  logic expIllegal;

  robCore robCore_inst (
    .clock(clock),
    .reset(reset),
    .dispatchValid(dispatchValid),
    .dispatchReq(dispatchReq),
    .completeReq(completeReq),
    .dispatchReady(dispatchReady),
    .retired(retired),
    .halted(halted),
    .illegalSeen(illegalSeen)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic failRun;
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic checkSlot(input int slot, input retireSlot_t got, input retireSlot_t exp);
    if (got !== exp) begin
      $display("error: retired[%0d] got %h expected %h", slot, got, exp);
      failRun();
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      failRun();
    end
  endtask

  // flags: 0 none, 1 halt, 2 illegal
  function automatic stimRow_t makeRow(input int d0, input int f0, input int d1,
                                       input int f1, input logic [2:0] mode);
    stimRow_t r;
    r.req[0].dest = `AREG_W'(d0);
    r.req[0].halt = (f0 == 1);
    r.req[0].illegal = (f0 == 2);
    r.req[1].dest = `AREG_W'(d1);
    r.req[1].halt = (f1 == 1);
    r.req[1].illegal = (f1 == 2);
    r.mode = mode;
    return r;
  endfunction

  task automatic loadStim;
    stim[0] = makeRow(1, 0, 2, 0, MODE_INORDER);
    stim[1] = makeRow(3, 0, 3, 0, MODE_REVERSE);
    stim[2] = makeRow(4, 0, 5, 0, MODE_HOLD);
    stim[3] = makeRow(6, 0, 4, 0, MODE_REVERSE);
    stim[4] = makeRow(7, 0, 8, 0, MODE_HOLD);
    stim[5] = makeRow(9, 0, 7, 0, MODE_HOLD);
    stim[6] = makeRow(1, 0, 10, 0, MODE_RANDOM);
    stim[7] = makeRow(11, 0, 11, 0, MODE_TIMING);
    stim[8] = makeRow(12, 0, 13, 0, MODE_HOLD);
    stim[9] = makeRow(14, 0, 15, 0, MODE_HOLD);
    stim[10] = makeRow(2, 0, 2, 0, MODE_HOLD);
    stim[11] = makeRow(16, 0, 17, 0, MODE_HOLD);
    stim[12] = makeRow(18, 0, 3, 0, MODE_HOLD);
    stim[13] = makeRow(19, 0, 20, 0, MODE_HOLD);
    // seventh pair in flight fills the ROB
    stim[14] = makeRow(21, 0, 22, 0, MODE_FULL);
    stim[15] = makeRow(25, 0, 26, 0, MODE_HOLD);
    stim[16] = makeRow(27, 0, 1, 0, MODE_HOLD);
    stim[17] = makeRow(28, 0, 29, 0, MODE_RANDOM);
    stim[18] = makeRow(30, 0, 31, 0, MODE_HOLD);
    stim[19] = makeRow(5, 1, 6, 0, MODE_STOP);
    stim[20] = makeRow(0, 0, 2, 0, MODE_INORDER);
    stim[21] = makeRow(3, 2, 4, 0, MODE_STOP);
  endtask

  task automatic stepCycle;
    @(posedge clock);
    #1;
  endtask

  task automatic resetAll;
    reset = 1'b1;
    dispatchValid = 1'b0;
    completeReq = '0;
    freeTags.delete();
    expectedQ.delete();
    pendingIdx.delete();
    for (int i = 0; i < FL_DEPTH; i++) begin
      freeTags.push_back(`PREG_W'(`NUM_AREG + i));
    end
    for (int i = 0; i < `NUM_AREG; i++) begin
      specMap[i] = `PREG_W'(i);
      archMap[i] = `PREG_W'(i);
    end
    pairCount = 0;
    expHalted = 1'b0;
    expIllegal = 1'b0;
    repeat (5) stepCycle();
    reset = 1'b0;
    checkFlag("dispatchReady", dispatchReady, 1'b0);
  endtask

  task automatic dispatchPair(input dispatchReq_t req);
    retireSlot_t exp;
    logic stopped;
    while (!dispatchReady) stepCycle();
    dispatchValid = 1'b1;
    dispatchReq = req;
    stepCycle();
    dispatchValid = 1'b0;
    stopped = 1'b0;
    // sequential update gives slot 1 the forwarded mapping
    for (int s = 0; s < `NUM_SUPER; s++) begin
      exp.valid = 1'b1;
      exp.dest = req[s].dest;
      exp.tag = freeTags.pop_front();
      exp.oldTag = specMap[req[s].dest];
      exp.halt = req[s].halt;
      exp.illegal = req[s].illegal;
      specMap[req[s].dest] = exp.tag;
      if (!stopped) begin
        expectedQ.push_back(exp);
      end
      if (req[s].halt | req[s].illegal) begin
        stopped = 1'b1;
      end else begin
        pendingIdx.push_back(`ROB_IDX_W'(2 * pairCount + s));
      end
    end
    pairCount++;
  endtask

  task automatic flushPending(input logic [2:0] mode);
    logic [`ROB_IDX_W-1:0] tmp;
    int j;
    // completions start in the second cycle after the strobe
    stepCycle();
    if (mode == MODE_REVERSE) begin
      for (int i = 0; i < pendingIdx.size() / 2; i++) begin
        j = pendingIdx.size() - 1 - i;
        tmp = pendingIdx[i];
        pendingIdx[i] = pendingIdx[j];
        pendingIdx[j] = tmp;
      end
    end else if (mode == MODE_RANDOM) begin
      for (int i = pendingIdx.size() - 1; i > 0; i--) begin
        j = $urandom_range(i, 0);
        tmp = pendingIdx[i];
        pendingIdx[i] = pendingIdx[j];
        pendingIdx[j] = tmp;
      end
    end
    while (pendingIdx.size() > 0) begin
      completeReq = '0;
      for (int p = 0; p < `NUM_SUPER; p++) begin
        if (pendingIdx.size() > 0) begin
          completeReq[p].valid = 1'b1;
          completeReq[p].idx = pendingIdx.pop_front();
        end
      end
      stepCycle();
    end
    completeReq = '0;
  endtask

  task automatic waitDrained;
    while (expectedQ.size() > 0) stepCycle();
  endtask

  // head entry completes alone, shows on retired two edges later
  task automatic timingCheck;
    stepCycle();
    completeReq[0].valid = 1'b1;
    completeReq[0].idx = pendingIdx.pop_front();
    stepCycle();
    completeReq = '0;
    @(negedge clock);
    checkFlag("retired[0].valid", retired[0].valid, 1'b0);
    @(negedge clock);
    checkFlag("retired[0].valid", retired[0].valid, 1'b1);
    stepCycle();
    flushPending(MODE_INORDER);
  endtask

  task automatic fullCheck;
    logic expReady;
    repeat (2) stepCycle();
    expReady = (`NUM_ROB - expectedQ.size() >= 2 * `NUM_SUPER)
               && (FL_DEPTH - expectedQ.size() >= `NUM_SUPER);
    repeat (3) begin
      checkFlag("dispatchReady", dispatchReady, expReady);
      stepCycle();
    end
    flushPending(MODE_REVERSE);
    // room for two pairs again once enough entries have retired
    while (expectedQ.size() > `NUM_ROB - 2 * `NUM_SUPER) stepCycle();
    checkFlag("dispatchReady", dispatchReady, 1'b1);
  endtask

  task automatic stopCheck;
    flushPending(MODE_INORDER);
    waitDrained();
    repeat (4) begin
      checkFlag("dispatchReady", dispatchReady, 1'b0);
      stepCycle();
    end
    resetAll();
  endtask

  always @(negedge clock) begin : retireMonitor
    retireSlot_t exp;
    if (!reset) begin
      for (int s = 0; s < `NUM_SUPER; s++) begin
        if (retired[s].valid) begin
          if (expectedQ.size() == 0) begin
            $display("retired[%0d] is valid while no instruction is outstanding", s);
            failRun();
          end else begin
            exp = expectedQ.pop_front();
            checkSlot(s, retired[s], exp);
            // old architectural mapping goes back to the free list
            freeTags.push_back(archMap[exp.dest]);
            archMap[exp.dest] = exp.tag;
            expHalted = expHalted | exp.halt;
            expIllegal = expIllegal | exp.illegal;
          end
        end
      end
      checkFlag("halted", halted, expHalted);
      checkFlag("illegalSeen", illegalSeen, expIllegal);
    end
  end

  initial begin
    repeat (NUM_ROWS * 40) @(posedge clock);
    $display("timeout: the stimulus table did not finish in %0d cycles", NUM_ROWS * 40);
    failRun();
  end

  initial begin
    void'($urandom(32'hb86e_f835));
    reset = 1'b1;
    dispatchValid = 1'b0;
    dispatchReq = '0;
    completeReq = '0;
    loadStim();
    resetAll();
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (stim[r].mode == MODE_TIMING) begin
        waitDrained();
      end
      dispatchPair(stim[r].req);
      case (stim[r].mode)
        MODE_INORDER, MODE_REVERSE, MODE_RANDOM: flushPending(stim[r].mode);
        MODE_TIMING: timingCheck();
        MODE_FULL: fullCheck();
        MODE_STOP: stopCheck();
        default: ;
      endcase
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== robCore.f ====
+incdir+.
robPkg.sv
commitPkg.sv
renameStage.sv
reorderBuffer.sv
commitStage.sv
robCore.sv
robCoreTb.sv

// ==== Bender.yml ====
package:
  name: robCore

sources:
  - include_dirs:
      - .
    files:
      - robPkg.sv
      - commitPkg.sv
      - renameStage.sv
      - reorderBuffer.sv
      - commitStage.sv
      - robCore.sv
      - target: simulation
        files:
          - robCoreTb.sv
